// File: common/wb_xbar_pkg.sv
// Wishbone crossbar shared definitions
package wb_xbar_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	// Port counts, the error target sits after the last slave
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES = 4;
	localparam int N_TARGETS = N_SLAVES + 1;
	localparam int MASTER_ID_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

	// Fixed address map, limits are inclusive
	localparam logic [ADDR_W-1:0] SLAVE0_BASE = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] SLAVE0_LIMIT = 32'h0000_0FFF;
	localparam logic [ADDR_W-1:0] SLAVE1_BASE = 32'h0000_1000;
	localparam logic [ADDR_W-1:0] SLAVE1_LIMIT = 32'h0000_1FFF;
	localparam logic [ADDR_W-1:0] SLAVE2_BASE = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] SLAVE2_LIMIT = 32'h0001_FFFF;
	localparam logic [ADDR_W-1:0] SLAVE3_BASE = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] SLAVE3_LIMIT = 32'h8000_FFFF;

	// Values line up with the target index
	typedef enum logic [2:0] {
		TGT_S0 = 3'd0,
		TGT_S1 = 3'd1,
		TGT_S2 = 3'd2,
		TGT_S3 = 3'd3,
		TGT_ERR = 3'd4,
		TGT_NONE = 3'd5
	} target_e;

	typedef enum logic {PORT_IDLE, PORT_BUSY} port_state_e;

	typedef enum logic {ARB_IDLE, ARB_GRANTED} arb_state_e;

	// Request from a master or towards a target
	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat_w;
		logic [SEL_W-1:0] sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// Response from a target
	typedef struct packed {
		logic [DATA_W-1:0] dat_r;
		logic ack;
		logic err;
	} wb_rsp_t;

endpackage

// File: wb_xbar/wb_master_port.sv
// Crossbar master port
`timescale 1ns/1ps

module wb_master_port (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t m_req_i,
	output wb_xbar_pkg::wb_rsp_t m_rsp_o,
	output logic [wb_xbar_pkg::N_TARGETS-1:0] tgt_req_o,
	input wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_TARGETS-1:0] tgt_rsp_i
);

	wb_xbar_pkg::port_state_e state_q;
	wb_xbar_pkg::target_e tgt_q;

	// Map an address onto a target, unmapped space goes to the error target
	function automatic wb_xbar_pkg::target_e decode(
		input logic [wb_xbar_pkg::ADDR_W-1:0] adr
	);
		if (adr >= wb_xbar_pkg::SLAVE0_BASE && adr <= wb_xbar_pkg::SLAVE0_LIMIT) begin
			return wb_xbar_pkg::TGT_S0;
		end
		if (adr >= wb_xbar_pkg::SLAVE1_BASE && adr <= wb_xbar_pkg::SLAVE1_LIMIT) begin
			return wb_xbar_pkg::TGT_S1;
		end
		if (adr >= wb_xbar_pkg::SLAVE2_BASE && adr <= wb_xbar_pkg::SLAVE2_LIMIT) begin
			return wb_xbar_pkg::TGT_S2;
		end
		if (adr >= wb_xbar_pkg::SLAVE3_BASE && adr <= wb_xbar_pkg::SLAVE3_LIMIT) begin
			return wb_xbar_pkg::TGT_S3;
		end
		return wb_xbar_pkg::TGT_ERR;
	endfunction

	// Target request and response select
	// Both stay zero while no cycle is open
	always_comb begin
		tgt_req_o = '0;
		m_rsp_o = '0;
		if (state_q == wb_xbar_pkg::PORT_BUSY) begin
			for (int t = 0; t < wb_xbar_pkg::N_TARGETS; t++) begin
				if (tgt_q == wb_xbar_pkg::target_e'(t)) begin
					tgt_req_o[t] = 1'b1;
					m_rsp_o = tgt_rsp_i[t];
				end
			end
		end
	end

	// Cycle tracking
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= wb_xbar_pkg::PORT_IDLE;
			tgt_q <= wb_xbar_pkg::TGT_NONE;
		end else begin
			case (state_q)
				wb_xbar_pkg::PORT_IDLE: begin
					// Latch the decoded target on a new strobe
					if (m_req_i.cyc && m_req_i.stb) begin
						state_q <= wb_xbar_pkg::PORT_BUSY;
						tgt_q <= decode(m_req_i.adr);
					end
				end
				wb_xbar_pkg::PORT_BUSY: begin
					// Cycle ends on ack or err from the selected target
					if (m_rsp_o.ack || m_rsp_o.err) begin
						state_q <= wb_xbar_pkg::PORT_IDLE;
						tgt_q <= wb_xbar_pkg::TGT_NONE;
					end
				end
				default: begin
					state_q <= wb_xbar_pkg::PORT_IDLE;
				end
			endcase
		end
	end

endmodule

// File: wb_xbar/wb_target_port.sv
// Crossbar target port with round-robin arbiter
`timescale 1ns/1ps

module wb_target_port (
	input logic clk,
	input logic rstn,
	input logic [wb_xbar_pkg::N_MASTERS-1:0] req_vec_i,
	input wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_MASTERS-1:0] m_req_i,
	output wb_xbar_pkg::wb_req_t t_req_o,
	input wb_xbar_pkg::wb_rsp_t t_rsp_i,
	output wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_MASTERS-1:0] m_rsp_o
);

	localparam int N = wb_xbar_pkg::N_MASTERS;

	wb_xbar_pkg::arb_state_e state_q;
	logic [N-1:0] gnt_q;
	logic [N-1:0] last_gnt_q;
	logic [wb_xbar_pkg::MASTER_ID_W-1:0] gnt_id_q;

	logic [N-1:0] above_last;
	logic [N-1:0] masked_gnt;
	logic [N-1:0] unmasked_gnt;
	logic [N-1:0] next_gnt;

	// Keep only the lowest set bit
	function automatic logic [N-1:0] lowest_one(input logic [N-1:0] vec);
		logic [N-1:0] one_hot;
		logic found;
		one_hot = '0;
		found = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (vec[i] && !found) begin
				one_hot[i] = 1'b1;
				found = 1'b1;
			end
		end
		return one_hot;
	endfunction

	// One-hot grant to master index
	function automatic logic [wb_xbar_pkg::MASTER_ID_W-1:0] gnt2id(input logic [N-1:0] gnt);
		logic [wb_xbar_pkg::MASTER_ID_W-1:0] id;
		id = '0;
		for (int i = 0; i < N; i++) begin
			if (gnt[i]) begin
				id = id | wb_xbar_pkg::MASTER_ID_W'(i);
			end
		end
		return id;
	endfunction

	// Masks requests at or below the last grant
	always_comb begin
		above_last[0] = 1'b0;
		for (int i = 1; i < N; i++) begin
			above_last[i] = above_last[i-1] | last_gnt_q[i-1];
		end
	end

	// Requests above the last grant win, else lowest index
	assign masked_gnt = lowest_one(req_vec_i & above_last);
	assign unmasked_gnt = lowest_one(req_vec_i);
	assign next_gnt = (|masked_gnt) ? masked_gnt : unmasked_gnt;

	// Registered grant
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= wb_xbar_pkg::ARB_IDLE;
			gnt_q <= '0;
			last_gnt_q <= '0;
			gnt_id_q <= '0;
		end else begin
			case (state_q)
				wb_xbar_pkg::ARB_IDLE: begin
					if (|next_gnt) begin
						state_q <= wb_xbar_pkg::ARB_GRANTED;
						gnt_q <= next_gnt;
						last_gnt_q <= next_gnt;
						gnt_id_q <= gnt2id(next_gnt);
					end
				end
				wb_xbar_pkg::ARB_GRANTED: begin
					// Release once the owner drops its request
					if ((gnt_q & req_vec_i) == '0) begin
						state_q <= wb_xbar_pkg::ARB_IDLE;
						gnt_q <= '0;
					end
				end
				default: begin
					state_q <= wb_xbar_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	// Forward the owner's request, route the response back to it only
	always_comb begin
		t_req_o = '0;
		m_rsp_o = '0;
		if (state_q == wb_xbar_pkg::ARB_GRANTED) begin
			t_req_o = m_req_i[gnt_id_q];
			m_rsp_o[gnt_id_q] = t_rsp_i;
		end
	end

endmodule

// File: design/wb_decode_err.sv
// Decode error target
`timescale 1ns/1ps

module wb_decode_err (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t req_i,
	output wb_xbar_pkg::wb_rsp_t rsp_o
);

	logic err_q;
	// Set after err fires, held until the strobe goes away
	logic fired_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
			fired_q <= 1'b0;
		end else begin
			// Single err pulse per strobe
			err_q <= req_i.cyc & req_i.stb & ~err_q & ~fired_q;
			fired_q <= (fired_q | err_q) & req_i.cyc & req_i.stb;
		end
	end

	// Never acks, read data always zero
	always_comb begin
		rsp_o.dat_r = '0;
		rsp_o.ack = 1'b0;
		rsp_o.err = err_q;
	end

endmodule

// File: design/wb_xbar_top.sv
// Wishbone 2x4 crossbar top
`timescale 1ns/1ps

module wb_xbar_top (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_MASTERS-1:0] m_req_i,
	output wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_MASTERS-1:0] m_rsp_o,
	output wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_SLAVES-1:0] s_req_o,
	input wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_SLAVES-1:0] s_rsp_i
);

	localparam int NM = wb_xbar_pkg::N_MASTERS;
	localparam int NT = wb_xbar_pkg::N_TARGETS;

	// One-hot target requests, seen per master and per target
	logic [NM-1:0][NT-1:0] m_tgt_req;
	logic [NT-1:0][NM-1:0] t_req_vec;
	// Responses, seen per target and per master
	wb_xbar_pkg::wb_rsp_t [NT-1:0][NM-1:0] t_m_rsp;
	wb_xbar_pkg::wb_rsp_t [NM-1:0][NT-1:0] m_t_rsp;
	// Target side request and response
	wb_xbar_pkg::wb_req_t [NT-1:0] t_req;
	wb_xbar_pkg::wb_rsp_t [NT-1:0] t_rsp;

	// Transpose between master and target views
	for (genvar m = 0; m < NM; m++) begin : g_xpose_m
		for (genvar t = 0; t < NT; t++) begin : g_xpose_t
			assign t_req_vec[t][m] = m_tgt_req[m][t];
			assign m_t_rsp[m][t] = t_m_rsp[t][m];
		end
	end

	// Real slaves take the low target indices
	assign s_req_o = t_req[wb_xbar_pkg::N_SLAVES-1:0];
	assign t_rsp[wb_xbar_pkg::N_SLAVES-1:0] = s_rsp_i;

	wb_master_port master_port0 (
		.clk(clk), .rstn(rstn), .m_req_i(m_req_i[0]), .m_rsp_o(m_rsp_o[0]),
		.tgt_req_o(m_tgt_req[0]), .tgt_rsp_i(m_t_rsp[0])
	);
	wb_master_port master_port1 (
		.clk(clk), .rstn(rstn), .m_req_i(m_req_i[1]), .m_rsp_o(m_rsp_o[1]),
		.tgt_req_o(m_tgt_req[1]), .tgt_rsp_i(m_t_rsp[1])
	);

	wb_target_port target_port0 (
		.clk(clk), .rstn(rstn), .req_vec_i(t_req_vec[0]), .m_req_i(m_req_i),
		.t_req_o(t_req[0]), .t_rsp_i(t_rsp[0]), .m_rsp_o(t_m_rsp[0])
	);
	wb_target_port target_port1 (
		.clk(clk), .rstn(rstn), .req_vec_i(t_req_vec[1]), .m_req_i(m_req_i),
		.t_req_o(t_req[1]), .t_rsp_i(t_rsp[1]), .m_rsp_o(t_m_rsp[1])
	);
	wb_target_port target_port2 (
		.clk(clk), .rstn(rstn), .req_vec_i(t_req_vec[2]), .m_req_i(m_req_i),
		.t_req_o(t_req[2]), .t_rsp_i(t_rsp[2]), .m_rsp_o(t_m_rsp[2])
	);
	wb_target_port target_port3 (
		.clk(clk), .rstn(rstn), .req_vec_i(t_req_vec[3]), .m_req_i(m_req_i),
		.t_req_o(t_req[3]), .t_rsp_i(t_rsp[3]), .m_rsp_o(t_m_rsp[3])
	);
	// Port for unmapped addresses
	wb_target_port target_port4 (
		.clk(clk), .rstn(rstn), .req_vec_i(t_req_vec[4]), .m_req_i(m_req_i),
		.t_req_o(t_req[4]), .t_rsp_i(t_rsp[4]), .m_rsp_o(t_m_rsp[4])
	);

	wb_decode_err decode_err0 (
		.clk(clk), .rstn(rstn),
		.req_i(t_req[wb_xbar_pkg::TGT_ERR]), .rsp_o(t_rsp[wb_xbar_pkg::TGT_ERR])
	);

endmodule

// File: test/wb_xbar_tb.sv
// Crossbar testbench
`timescale 1ns/1ps

module wb_xbar_tb;

	localparam int NM = wb_xbar_pkg::N_MASTERS;
	localparam int NS = wb_xbar_pkg::N_SLAVES;
	// Words modeled per slave
	localparam int WORDS = 64;
	// Transactions per test
	localparam int T2_PER_SLAVE = 8;
	localparam int T3_COUNT = 16;
	localparam int T4_PER_MASTER = 200;
	localparam int T5_PER_MASTER = 10;
	// Plus one lone access ahead of the round-robin rounds
	localparam int N_TXN = NS * T2_PER_SLAVE * 2 + T3_COUNT
		+ NM * (T4_PER_MASTER + T5_PER_MASTER) + 1;
	// Worst case of 40 cycles per transaction
	localparam int CYCLE_LIMIT = N_TXN * 40;

	logic clk;
	logic rstn;
	wb_xbar_pkg::wb_req_t [NM-1:0] m_req;
	wb_xbar_pkg::wb_rsp_t [NM-1:0] m_rsp;
	wb_xbar_pkg::wb_req_t [NS-1:0] s_req;
	wb_xbar_pkg::wb_rsp_t [NS-1:0] s_rsp;

	// Slave memories and the reference shadow memory
	logic [31:0] slave_mem [NS][WORDS];
	logic [31:0] shadow [NS][WORDS];
	// Address each slave acknowledged, cleared once checked
	logic [31:0] served_adr [NS];
	int stb_cycles;
	// Master served last at slave 2
	int last_s2;
	// First master to finish in a round
	int first_done;
	int cycle_cnt;
	int check_cnt;
	int err_cnt;
	int err_at_start;
	int tests_run;
	int tests_failed;
	string cur_test;

	wb_xbar_top dut0 (
		.clk(clk), .rstn(rstn), .m_req_i(m_req), .m_rsp_o(m_rsp),
		.s_req_o(s_req), .s_rsp_i(s_rsp)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Byte merge under select
	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = dat[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] slave_base(input int s);
		case (s)
			0: return wb_xbar_pkg::SLAVE0_BASE;
			1: return wb_xbar_pkg::SLAVE1_BASE;
			2: return wb_xbar_pkg::SLAVE2_BASE;
			default: return wb_xbar_pkg::SLAVE3_BASE;
		endcase
	endfunction

	// Word address in one of three holes of the map
	function automatic logic [31:0] unmapped_adr();
		int region;
		region = $urandom_range(0, 2);
		if (region == 0) begin
			return 32'h0000_2000 + ($urandom_range(0, 14335) << 2);
		end
		if (region == 1) begin
			return 32'h0002_0000 + ($urandom & 32'h3FFF_FFFC);
		end
		return 32'h9000_0000 + ($urandom & 32'h0FFF_FFFC);
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_at_start = err_cnt;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_cnt != err_at_start) begin
			tests_failed++;
			$display("test %s: FAIL, %0d errors", cur_test, err_cnt - err_at_start);
		end else begin
			$display("test %s: pass", cur_test);
		end
	endtask

	// One slave access with 0 to 3 wait states and a single ack cycle
	task automatic serve(input int s);
		int waits;
		int w;
		waits = $urandom_range(0, 3);
		repeat (waits) @(posedge clk);
		#1;
		w = s_req[s].adr[7:2];
		if (s_req[s].we) begin
			slave_mem[s][w] = merge_bytes(slave_mem[s][w], s_req[s].dat_w, s_req[s].sel);
		end
		s_rsp[s].dat_r = slave_mem[s][w];
		s_rsp[s].ack = 1'b1;
		served_adr[s] = s_req[s].adr;
		@(posedge clk);
		#1;
		s_rsp[s] = '0;
	endtask

	for (genvar s = 0; s < NS; s++) begin : g_slave
		always begin
			@(posedge clk);
			if (rstn && s_req[s].cyc && s_req[s].stb) begin
				serve(s);
			end
		end
	end

	// Counts strobe cycles seen on any slave
	always @(posedge clk) begin
		for (int s = 0; s < NS; s++) begin
			if (s_req[s].cyc && s_req[s].stb) begin
				stb_cycles = stb_cycles + 1;
			end
		end
	end

	// Classic cycle that drops stb right after ack or err
	task automatic bus_access(input int m, input logic [31:0] adr, input logic we,
		input logic [3:0] sel, input logic [31:0] dat, output logic [31:0] rdat,
		output logic ack, output logic err);
		logic done;
		done = 1'b0;
		@(posedge clk);
		#1;
		m_req[m].adr = adr;
		m_req[m].dat_w = dat;
		m_req[m].sel = sel;
		m_req[m].we = we;
		m_req[m].cyc = 1'b1;
		m_req[m].stb = 1'b1;
		while (!done) begin
			@(posedge clk);
			done = m_rsp[m].ack | m_rsp[m].err;
		end
		ack = m_rsp[m].ack;
		err = m_rsp[m].err;
		rdat = m_rsp[m].dat_r;
		#1;
		m_req[m] = '0;
	endtask

	// Mapped access checked against the shadow memory
	task automatic txn(input int m, input int s, input int w, input logic we);
		logic [31:0] adr;
		logic [31:0] wdat;
		logic [31:0] rdat;
		logic [3:0] sel;
		logic ack;
		logic err;
		adr = slave_base(s) + 32'(w * 4);
		sel = 4'($urandom_range(1, 15));
		wdat = $urandom;
		bus_access(m, adr, we, sel, wdat, rdat, ack, err);
		check("ack", 32'd1, 32'(ack));
		check("err", 32'd0, 32'(err));
		check("address seen by slave", adr, served_adr[s]);
		served_adr[s] = '1;
		if (we) begin
			shadow[s][w] = merge_bytes(shadow[s][w], wdat, sel);
		end else begin
			check("read data", shadow[s][w], rdat);
		end
	endtask

	task automatic bad_txn(input int m);
		logic [31:0] rdat;
		logic ack;
		logic err;
		bus_access(m, unmapped_adr(), 1'($urandom_range(0, 1)), 4'hF, $urandom, rdat, ack, err);
		check("ack", 32'd0, 32'(ack));
		check("err", 32'd1, 32'(err));
		check("read data", 32'd0, rdat);
	endtask

	// Master 0 on even words, master 1 on odd words
	task automatic rand_loop(input int m, input int n);
		repeat (n) begin
			txn(m, $urandom_range(0, NS - 1), 2 * $urandom_range(0, WORDS / 2 - 1) + m,
				1'($urandom_range(0, 1)));
		end
	endtask

	// One access to slave 2 in a round where both masters start together
	// The first to finish must be the master next in turn
	task automatic fair_txn(input int m);
		txn(m, 2, 2 * $urandom_range(0, WORDS / 2 - 1) + m, 1'($urandom_range(0, 1)));
		if (first_done < 0) begin
			first_done = m;
			check("master served first", 32'(1 - last_s2), 32'(m));
		end else begin
			last_s2 = m;
		end
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Run timed out after %0d cycles, a transaction never completed", cycle_cnt);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin : main
		int t2_words [T2_PER_SLAVE];
		int stb_before;
		void'($urandom(32'he4b82568));
		rstn = 1'b0;
		m_req = '0;
		s_rsp = '0;
		stb_cycles = 0;
		last_s2 = 0;
		first_done = -1;
		check_cnt = 0;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int s = 0; s < NS; s++) begin
			served_adr[s] = '1;
			for (int w = 0; w < WORDS; w++) begin
				slave_mem[s][w] = '0;
				shadow[s][w] = '0;
			end
		end
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;

		start_test("reset_idle");
		repeat (2) @(posedge clk);
		for (int s = 0; s < NS; s++) begin
			check("slave cyc and stb", 32'd0, 32'({s_req[s].cyc, s_req[s].stb}));
		end
		for (int m = 0; m < NM; m++) begin
			check("master ack and err", 32'd0, 32'({m_rsp[m].ack, m_rsp[m].err}));
		end
		end_test();

		// Writes first, then reads of the same words
		start_test("write_read_all_slaves");
		for (int s = 0; s < NS; s++) begin
			for (int i = 0; i < T2_PER_SLAVE; i++) begin
				t2_words[i] = 2 * $urandom_range(0, WORDS / 2 - 1);
				txn(0, s, t2_words[i], 1'b1);
			end
			for (int i = 0; i < T2_PER_SLAVE; i++) begin
				txn(0, s, t2_words[i], 1'b0);
			end
		end
		end_test();

		start_test("unmapped_error");
		stb_before = stb_cycles;
		for (int i = 0; i < T3_COUNT; i++) begin
			bad_txn(i % NM);
		end
		check("slave strobe cycles", 32'(stb_before), 32'(stb_cycles));
		end_test();

		start_test("random_both_masters");
		fork
			rand_loop(0, T4_PER_MASTER);
			rand_loop(1, T4_PER_MASTER);
		join
		end_test();

		start_test("round_robin_slave2");
		// A lone access by master 0 leaves master 1 next in turn
		txn(0, 2, 0, 1'b1);
		last_s2 = 0;
		for (int r = 0; r < T5_PER_MASTER; r++) begin
			first_done = -1;
			fork
				fair_txn(0);
				fair_txn(1);
			join
		end
		end_test();

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: sources.f
common/wb_xbar_pkg.sv
wb_xbar/wb_master_port.sv
wb_xbar/wb_target_port.sv
design/wb_decode_err.sv
design/wb_xbar_top.sv
test/wb_xbar_tb.sv

// File: Bender.yml
package:
  name: wb_xbar

dependencies: {}

sources:
  # Shared package
  - files:
      - common/wb_xbar_pkg.sv
  # Crossbar RTL
  - files:
      - wb_xbar/wb_master_port.sv
      - wb_xbar/wb_target_port.sv
      - design/wb_decode_err.sv
      - design/wb_xbar_top.sv
  # Testbench
  - target: test
    files:
      - test/wb_xbar_tb.sv
